// ==== pipe_settings.svh ====
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

// data word and register file.
`define DATA_W 32
`define RADDR_W 5

// program counter.
`define PC_W 32

// exception fields.
`define CSR_NUM_W 14
`define ECODE_W 6

`endif

// ==== pipe_pkg.sv ====
`include "pipe_settings.svh"

package pipe_pkg;

    typedef enum logic [2:0] {
        ld_none = 3'd0,
        ld_b    = 3'd1, // byte, sign extended.
        ld_bu   = 3'd2,
        ld_h    = 3'd3, // half, sign extended.
        ld_hu   = 3'd4,
        ld_w    = 3'd5
    } load_kind_e;

    typedef enum logic [2:0] {
        src_alu    = 3'd0,
        src_load   = 3'd1,
        src_mul_lo = 3'd2,
        src_mul_hi = 3'd3,
        src_div    = 3'd4
    } res_src_e;

    typedef struct packed {
        logic                  ex;   // instruction raises an exception.
        logic                  ertn; // exception return.
        logic [`ECODE_W-1:0]   ecode;
        logic [`CSR_NUM_W-1:0] csr_num;
    } excep_t;

    typedef struct packed {
        logic                rf_we;
        logic [`RADDR_W-1:0] waddr;
        logic [`PC_W-1:0]    pc;
        logic [`DATA_W-1:0]  alu_result; // also the load address.
        load_kind_e          ld_kind;
        res_src_e            res_src;
        logic [`DATA_W-1:0]  div_result;
        excep_t              excep;
    } ex_to_mem_t;

    typedef struct packed {
        logic                rf_we;
        logic [`RADDR_W-1:0] waddr;
        logic [`DATA_W-1:0]  wdata;
        logic [`PC_W-1:0]    pc;
        excep_t              excep;
    } mem_to_wb_t;

endpackage

// ==== stage_if.sv ====
`timescale 1ns/1ns

interface stage_if #(
    parameter type payload_t = logic [31:0]
) ();

    logic     valid;
    logic     allowin;
    payload_t payload;
    logic     flush; // driven by the top from the writeback stage.

    // sending stage holds payload until valid and allowin meet.
    modport upstream (
        output valid,
        output payload,
        input  allowin,
        input  flush
    );

    modport downstream (
        input  valid,
        input  payload,
        input  flush,
        output allowin
    );

endinterface

// ==== ex_issue.sv ====
`timescale 1ns/1ns
`include "pipe_settings.svh"

module ex_issue (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  pipe_pkg::ex_to_mem_t in_payload,
    input  logic [`DATA_W-1:0]   mul_a,
    input  logic [`DATA_W-1:0]   mul_b,
    input  logic                 mem_excep,
    output logic                 data_sram_en,
    output logic [`DATA_W-1:0]   data_sram_addr,
    output logic [63:0]          mul_product,
    stage_if.upstream            out
);
    import pipe_pkg::*;

    logic               ex_valid;
    ex_to_mem_t         ex_q;
    logic [`DATA_W-1:0] mul_a_q;
    logic [`DATA_W-1:0] mul_b_q;
    logic               ex_allowin;
    logic               accept;
    logic               to_mem;
    logic               is_load;

    assign ex_allowin = ~ex_valid | out.allowin | out.flush;
    assign in_ready   = ex_allowin & ~out.flush; // nothing enters while the pipe is flushed.
    assign accept     = in_valid & in_ready;
    assign to_mem     = ex_valid & out.allowin & ~out.flush;
    assign is_load    = (ex_q.ld_kind != ld_none);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid <= 1'b0;
        end else if (out.flush) begin
            ex_valid <= 1'b0;
        end else if (ex_allowin) begin
            ex_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ex_q    <= in_payload;
            mul_a_q <= mul_a;
            mul_b_q <= mul_b;
        end
    end

    // product lands together with the entry in mem.
    always_ff @(posedge clk) begin
        if (to_mem) begin
            mul_product <= 64'(mul_a_q) * 64'(mul_b_q);
        end
    end

    assign out.valid   = ex_valid;
    assign out.payload = ex_q;

    // an older excepting entry in mem blocks the read.
    assign data_sram_en   = to_mem & is_load & ~mem_excep;
    assign data_sram_addr = {ex_q.alu_result[`DATA_W-1:2], 2'b00};

endmodule

// ==== mem_stage.sv ====
`timescale 1ns/1ns
`include "pipe_settings.svh"

module mem_stage (
    input  logic               clk,
    input  logic               resetn,
    stage_if.downstream        in,
    input  logic [`DATA_W-1:0] data_sram_rdata,
    input  logic [63:0]        mul_product,
    output logic               mem_excep,
    stage_if.upstream          out
);
    import pipe_pkg::*;

    logic               mem_valid;
    logic               mem_first; // first cycle of a new entry, rdata is live.
    ex_to_mem_t         mem_q;
    logic [`DATA_W-1:0] rdata_hold;
    logic               take;
    logic [`DATA_W-1:0] ld_word;
    logic [`DATA_W-1:0] shifted;
    logic [`DATA_W-1:0] ld_data;
    logic [`DATA_W-1:0] wdata;

    assign in.allowin = ~mem_valid | out.allowin | in.flush;
    assign take       = in.valid & in.allowin & ~in.flush;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
        end else if (in.flush) begin
            mem_valid <= 1'b0;
        end else if (in.allowin) begin
            mem_valid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_first <= 1'b0;
        end else begin
            mem_first <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            mem_q <= in.payload;
        end
    end

    // keep the load word so a stall behind wb does not lose it.
    always_ff @(posedge clk) begin
        if (mem_first) begin
            rdata_hold <= data_sram_rdata;
        end
    end

    assign ld_word = mem_first ? data_sram_rdata : rdata_hold;
    assign shifted = ld_word >> {mem_q.alu_result[1:0], 3'b000};

    always_comb begin
        case (mem_q.ld_kind)
            ld_b:    ld_data = {{24{shifted[7]}}, shifted[7:0]};
            ld_bu:   ld_data = {24'b0, shifted[7:0]};
            ld_h:    ld_data = {{16{shifted[15]}}, shifted[15:0]};
            ld_hu:   ld_data = {16'b0, shifted[15:0]};
            default: ld_data = shifted; // word access is already aligned.
        endcase
    end

    always_comb begin
        case (mem_q.res_src)
            src_load:   wdata = ld_data;
            src_mul_lo: wdata = mul_product[31:0];
            src_mul_hi: wdata = mul_product[63:32];
            src_div:    wdata = mem_q.div_result;
            default:    wdata = mem_q.alu_result;
        endcase
    end

    assign out.valid   = mem_valid;
    assign out.payload = '{
        rf_we: mem_q.rf_we,
        waddr: mem_q.waddr,
        wdata: wdata,
        pc:    mem_q.pc,
        excep: mem_q.excep
    };

    assign mem_excep = mem_valid & (mem_q.excep.ex | mem_q.excep.ertn);

endmodule

// ==== wb_stage.sv ====
`timescale 1ns/1ns
`include "pipe_settings.svh"

module wb_stage (
    input  logic                clk,
    input  logic                resetn,
    stage_if.downstream         in,
    output logic                retire_valid,
    input  logic                retire_ready,
    output logic [`PC_W-1:0]    retire_pc,
    output logic [`DATA_W-1:0]  retire_wdata,
    output logic [`RADDR_W-1:0] retire_waddr,
    output logic                retire_we,
    output pipe_pkg::excep_t    retire_excep,
    output logic                flush,
    input  logic [`RADDR_W-1:0] rf_raddr,
    output logic [`DATA_W-1:0]  rf_rdata
);
    import pipe_pkg::*;

    logic               wb_valid;
    mem_to_wb_t         wb_q;
    logic               retire_fire;
    logic               rf_wen;
    logic [`DATA_W-1:0] rf [2**`RADDR_W];

    assign retire_fire = wb_valid & retire_ready;
    assign flush       = retire_fire & (wb_q.excep.ex | wb_q.excep.ertn);

    assign in.allowin = ~wb_valid | retire_ready | in.flush;

    // an entry behind a retiring exception is not taken.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (in.allowin) begin
            wb_valid <= in.valid & ~in.flush;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid & in.allowin & ~in.flush) begin
            wb_q <= in.payload;
        end
    end

    assign retire_valid = wb_valid;
    assign retire_pc    = wb_q.pc;
    assign retire_wdata = wb_q.wdata;
    assign retire_waddr = wb_q.waddr;
    assign retire_we    = wb_q.rf_we;
    assign retire_excep = wb_q.excep;

    assign rf_wen = retire_fire & wb_q.rf_we & (wb_q.waddr != '0) & ~wb_q.excep.ex;

    always_ff @(posedge clk) begin
        if (rf_wen) begin
            rf[wb_q.waddr] <= wb_q.wdata;
        end
    end

    assign rf_rdata = (rf_raddr == '0) ? '0 : rf[rf_raddr]; // r0 is hardwired.

endmodule

// ==== mem_wb_top.sv ====
`timescale 1ns/1ns
`include "pipe_settings.svh"

module mem_wb_top (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  pipe_pkg::ex_to_mem_t in_payload,
    input  logic [`DATA_W-1:0]   mul_a,
    input  logic [`DATA_W-1:0]   mul_b,
    output logic                 data_sram_en,
    output logic [`DATA_W-1:0]   data_sram_addr,
    input  logic [`DATA_W-1:0]   data_sram_rdata,
    output logic                 retire_valid,
    input  logic                 retire_ready,
    output logic [`PC_W-1:0]     retire_pc,
    output logic [`DATA_W-1:0]   retire_wdata,
    output logic [`RADDR_W-1:0]  retire_waddr,
    output logic                 retire_we,
    output pipe_pkg::excep_t     retire_excep,
    output logic                 flush,
    input  logic [`RADDR_W-1:0]  rf_raddr,
    output logic [`DATA_W-1:0]   rf_rdata
);
    import pipe_pkg::*;

    logic [63:0] mul_product;
    logic        mem_excep;

    stage_if #(.payload_t(ex_to_mem_t)) ex_mem_if ();
    stage_if #(.payload_t(mem_to_wb_t)) mem_wb_if ();

    assign ex_mem_if.flush = flush;
    assign mem_wb_if.flush = flush;

    ex_issue i_ex_issue (
        .clk            (clk),
        .resetn         (resetn),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_payload     (in_payload),
        .mul_a          (mul_a),
        .mul_b          (mul_b),
        .mem_excep      (mem_excep),
        .data_sram_en   (data_sram_en),
        .data_sram_addr (data_sram_addr),
        .mul_product    (mul_product),
        .out            (ex_mem_if.upstream)
    );

    mem_stage i_mem_stage (
        .clk             (clk),
        .resetn          (resetn),
        .in              (ex_mem_if.downstream),
        .data_sram_rdata (data_sram_rdata),
        .mul_product     (mul_product),
        .mem_excep       (mem_excep),
        .out             (mem_wb_if.upstream)
    );

    wb_stage i_wb_stage (
        .clk          (clk),
        .resetn       (resetn),
        .in           (mem_wb_if.downstream),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire_pc    (retire_pc),
        .retire_wdata (retire_wdata),
        .retire_waddr (retire_waddr),
        .retire_we    (retire_we),
        .retire_excep (retire_excep),
        .flush        (flush),
        .rf_raddr     (rf_raddr),
        .rf_rdata     (rf_rdata)
    );

endmodule

// ==== mem_wb_properties.sv ====
`timescale 1ns/1ns
`include "pipe_settings.svh"

module mem_wb_properties (
    input logic                clk,
    input logic                resetn,
    input logic                in_ready,
    input logic                retire_valid,
    input logic                retire_ready,
    input logic [`PC_W-1:0]    retire_pc,
    input logic [`DATA_W-1:0]  retire_wdata,
    input logic [`RADDR_W-1:0] retire_waddr,
    input logic                flush,
    input logic                data_sram_en,
    input logic                mem_valid,
    input logic [2:0]          mem_ld_kind
);

    // a stalled retire keeps its entry.
    a_retire_hold: assert property (@(posedge clk) disable iff (!resetn)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire_pc)
            && $stable(retire_wdata) && $stable(retire_waddr))
        else $error("retire entry changed while stalled");

    a_reset_quiet: assert property (@(posedge clk)
        !resetn && $past(!resetn) |-> !retire_valid)
        else $error("retire_valid high during reset");

    // the read is paired with the load entry that lands in mem.
    a_load_read: assert property (@(posedge clk) disable iff (!resetn)
        data_sram_en |=> mem_valid && mem_ld_kind != 3'd0)
        else $error("memory read not followed by a load entry in mem");

    // a flush comes from a retiring entry and empties the pipe behind it.
    a_flush_retire: assert property (@(posedge clk) disable iff (!resetn)
        flush |=> $past(retire_valid) && !retire_valid && in_ready && !data_sram_en)
        else $error("flush without retire_valid or pipe not emptied");

endmodule

bind mem_wb_top mem_wb_properties i_mem_wb_properties (
    .clk          (clk),
    .resetn       (resetn),
    .in_ready     (in_ready),
    .retire_valid (retire_valid),
    .retire_ready (retire_ready),
    .retire_pc    (retire_pc),
    .retire_wdata (retire_wdata),
    .retire_waddr (retire_waddr),
    .flush        (flush),
    .data_sram_en (data_sram_en),
    .mem_valid    (mem_wb_if.valid),
    .mem_ld_kind  (i_mem_stage.mem_q.ld_kind)
);

// ==== tb_mem_wb.sv ====
`timescale 1ns/1ns
`include "pipe_settings.svh"

module tb_mem_wb;
    import pipe_pkg::*;

    typedef struct {
        logic [2:0]  ld;
        logic [2:0]  src;
        logic [31:0] alu;
        logic [31:0] divr;
        logic [31:0] ma;
        logic [31:0] mb;
        logic        we;
        logic [4:0]  waddr;
        logic        ex;
        logic        ertn;
        logic        expect_ret; // row is dropped by a flush when low.
    } row_t;

    typedef struct {
        logic [31:0] pc;
        logic [31:0] wdata;
        logic [4:0]  waddr;
        logic        we;
        excep_t      excep;
    } exp_t;

    logic                clk = 1'b0;
    logic                resetn = 1'b0;
    logic                in_valid = 1'b0;
    logic                in_ready;
    ex_to_mem_t          in_payload = '0;
    logic [`DATA_W-1:0]  mul_a = '0;
    logic [`DATA_W-1:0]  mul_b = '0;
    logic                data_sram_en;
    logic [`DATA_W-1:0]  data_sram_addr;
    logic [`DATA_W-1:0]  data_sram_rdata = '0;
    logic                retire_valid;
    logic                retire_ready = 1'b1;
    logic [`PC_W-1:0]    retire_pc;
    logic [`DATA_W-1:0]  retire_wdata;
    logic [`RADDR_W-1:0] retire_waddr;
    logic                retire_we;
    excep_t              retire_excep;
    logic                flush;
    logic [`RADDR_W-1:0] rf_raddr = '0;
    logic [`DATA_W-1:0]  rf_rdata;

    row_t        table_q[$];
    exp_t        exp_q[$];
    logic [31:0] rf_model[32];
    logic        written[32];
    logic [15:0] lfsr = 16'd11;
    logic        stall_mode = 1'b0;
    logic [31:0] next_pc = 32'h0000_8000;
    int          errors = 0;
    int          failed_tests = 0;
    int          tests = 0;
    int          reads_seen = 0;
    int          reads_expected = 0;

    mem_wb_top i_mem_wb_top (.*);

    initial begin
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        mem_word = (a * 32'h9E37_79B1 + a) ^ 32'hA5C3_5A3C;
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function logic take_bit();
        lfsr = lfsr_next(lfsr);
        take_bit = lfsr[0];
    endfunction

    function automatic logic [31:0] load_value(input logic [2:0] ld, input logic [31:0] a);
        logic [31:0] sh;
        sh = mem_word({a[31:2], 2'b00}) >> {a[1:0], 3'b000};
        case (ld)
            3'd1:    load_value = {{24{sh[7]}}, sh[7:0]};
            3'd2:    load_value = {24'b0, sh[7:0]};
            3'd3:    load_value = {{16{sh[15]}}, sh[15:0]};
            3'd4:    load_value = {16'b0, sh[15:0]};
            default: load_value = sh;
        endcase
    endfunction

    function automatic logic [31:0] expected_wdata(input row_t r);
        logic [63:0] prod;
        prod = {32'b0, r.ma} * {32'b0, r.mb};
        case (r.src)
            3'd1:    expected_wdata = load_value(r.ld, r.alu);
            3'd2:    expected_wdata = prod[31:0];
            3'd3:    expected_wdata = prod[63:32];
            3'd4:    expected_wdata = r.divr;
            default: expected_wdata = r.alu;
        endcase
    endfunction

    function automatic excep_t excep_fields(input row_t r);
        excep_fields.ex      = r.ex;
        excep_fields.ertn    = r.ertn;
        excep_fields.ecode   = r.ex ? 6'h0b : 6'h00;
        excep_fields.csr_num = r.alu[13:0]; // varied csr numbers ride along.
    endfunction

    task automatic abort_run(input string what);
        $display("%s at %0t", what, $time);
        $display("Checks failed");
        $finish;
    endtask

    task automatic add_row(input logic [2:0] ld, input logic [2:0] src, input logic [31:0] alu,
                           input logic [31:0] divr, input logic [31:0] ma, input logic [31:0] mb,
                           input logic we, input logic [4:0] waddr, input logic ex,
                           input logic ertn, input logic expect_ret);
        row_t r;
        r = '{ld, src, alu, divr, ma, mb, we, waddr, ex, ertn, expect_ret};
        table_q.push_back(r);
    endtask

    task automatic drive_row(input row_t r);
        in_valid              <= 1'b1;
        in_payload.rf_we      <= r.we;
        in_payload.waddr      <= r.waddr;
        in_payload.pc         <= next_pc;
        in_payload.alu_result <= r.alu;
        in_payload.ld_kind    <= load_kind_e'(r.ld);
        in_payload.res_src    <= res_src_e'(r.src);
        in_payload.div_result <= r.divr;
        in_payload.excep      <= excep_fields(r);
        mul_a                 <= r.ma;
        mul_b                 <= r.mb;
    endtask

    task automatic record_accept(input row_t r);
        exp_t e;
        if (r.expect_ret) begin
            e = '{next_pc, expected_wdata(r), r.waddr, r.we, excep_fields(r)};
            exp_q.push_back(e);
            if (r.ld != 3'd0) reads_expected++;
        end
        next_pc = next_pc + 32'd4;
    endtask

    // applies every row of the table back to back.
    task automatic apply_table();
        int wait_cnt;
        foreach (table_q[i]) begin
            drive_row(table_q[i]);
            wait_cnt = 0;
            do begin
                @(posedge clk);
                wait_cnt++;
                if (wait_cnt > 200) abort_run("timeout waiting for in_ready");
            end while (!in_ready);
            record_accept(table_q[i]);
        end
        in_valid <= 1'b0;
        table_q.delete();
    endtask

    task automatic drain();
        int wait_cnt;
        wait_cnt = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            wait_cnt++;
            if (wait_cnt > 2000) abort_run("timeout waiting for expected retires");
        end
        repeat (6) @(posedge clk);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        if (reads_seen != reads_expected) begin
            $display("CHECK FAILED at %0t: %0d memory reads, expected %0d",
                     $time, reads_seen, reads_expected);
            errors++;
        end
        if (errors != errors_before) failed_tests++;
        $display("test %0d %s: %s", tests, name, (errors == errors_before) ? "ok" : "FAILED");
    endtask

    always @(posedge clk) begin
        if (data_sram_en) begin
            data_sram_rdata <= mem_word(data_sram_addr);
            reads_seen++;
        end
    end

    always @(posedge clk) begin
        if (!resetn) retire_ready <= 1'b1;
        else if (stall_mode) retire_ready <= take_bit();
        else retire_ready <= 1'b1;
    end

    // in-order collector of retired instructions.
    always @(posedge clk) begin
        exp_t e;
        if (resetn && retire_valid && retire_ready) begin
            if (exp_q.size() == 0) begin
                $display("CHECK FAILED at %0t: unexpected retire of pc %h", $time, retire_pc);
                errors++;
            end else begin
                e = exp_q.pop_front();
                if (retire_pc !== e.pc || retire_wdata !== e.wdata || retire_waddr !== e.waddr
                    || retire_we !== e.we || retire_excep !== e.excep) begin
                    $display("CHECK FAILED at %0t: pc %h wdata %h, expected pc %h wdata %h",
                             $time, retire_pc, retire_wdata, e.pc, e.wdata);
                    errors++;
                end
                if (flush !== (e.excep.ex | e.excep.ertn)) begin
                    $display("CHECK FAILED at %0t: flush %b on retire of pc %h",
                             $time, flush, retire_pc);
                    errors++;
                end
                if (e.we && e.waddr != 5'd0 && !e.excep.ex) begin
                    rf_model[e.waddr] = e.wdata;
                    written[e.waddr]  = 1'b1;
                end
            end
        end
    end

    initial begin
        int e0;
        int n;
        foreach (written[i]) written[i] = 1'b0;
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);

        e0 = errors;
        for (int k = 1; k <= 5; k++) begin
            for (int off = 0; off < 4; off++) begin
                add_row(3'(k), 3'd1, 32'h0000_1000 + 32'(k * 16 + off), 32'h0, 32'h0, 32'h0,
                        1'b1, 5'(1 + (k * 4 + off) % 31), 1'b0, 1'b0, 1'b1);
            end
        end
        apply_table();
        drain();
        finish_test("load kinds and offsets", e0);

        e0 = errors;
        add_row(3'd0, 3'd0, 32'h1234_5678, 32'h0, 32'h0, 32'h0, 1'b1, 5'd3, 1'b0, 1'b0, 1'b1);
        add_row(3'd0, 3'd2, 32'h0, 32'h0, 32'hFFFF_FFF1, 32'h8000_0003, 1'b1, 5'd4,
                1'b0, 1'b0, 1'b1);
        add_row(3'd0, 3'd3, 32'h0, 32'h0, 32'hFFFF_FFF1, 32'h8000_0003, 1'b1, 5'd5,
                1'b0, 1'b0, 1'b1);
        add_row(3'd0, 3'd4, 32'h0, 32'hDEAD_BEEF, 32'h0, 32'h0, 1'b1, 5'd6, 1'b0, 1'b0, 1'b1);
        add_row(3'd0, 3'd0, 32'h5555_AAAA, 32'h0, 32'h0, 32'h0, 1'b1, 5'd0, 1'b0, 1'b0, 1'b1);
        add_row(3'd0, 3'd0, 32'h0BAD_0BAD, 32'h0, 32'h0, 32'h0, 1'b0, 5'd7, 1'b0, 1'b0, 1'b1);
        apply_table();
        drain();
        finish_test("alu, multiply and divide sources", e0);

        e0 = errors;
        add_row(3'd0, 3'd0, 32'hEEEE_0001, 32'h0, 32'h0, 32'h0, 1'b1, 5'd8, 1'b1, 1'b0, 1'b1);
        add_row(3'd5, 3'd1, 32'h0000_2000, 32'h0, 32'h0, 32'h0, 1'b1, 5'd9, 1'b0, 1'b0, 1'b0);
        add_row(3'd1, 3'd1, 32'h0000_2005, 32'h0, 32'h0, 32'h0, 1'b1, 5'd10, 1'b0, 1'b0, 1'b0);
        add_row(3'd5, 3'd1, 32'h0000_3000, 32'h0, 32'h0, 32'h0, 1'b1, 5'd11, 1'b0, 1'b0, 1'b1);
        add_row(3'd0, 3'd0, 32'h0000_0777, 32'h0, 32'h0, 32'h0, 1'b1, 5'd12, 1'b0, 1'b1, 1'b1);
        add_row(3'd0, 3'd0, 32'h0000_0888, 32'h0, 32'h0, 32'h0, 1'b1, 5'd13, 1'b0, 1'b0, 1'b0);
        apply_table();
        drain();
        finish_test("exception flush", e0);

        e0 = errors;
        stall_mode = 1'b1;
        for (int i = 0; i < 24; i++) begin
            add_row(3'((i % 5) + 1), 3'(((i % 3) == 0) ? 1 : (i % 5)),
                    32'h0000_4000 + 32'(i * 7), 32'h0100_0000 + 32'(i),
                    32'(i * 12345 + 1), 32'hF000_0000 + 32'(i), 1'b1, 5'(14 + (i % 18)),
                    1'b0, 1'b0, 1'b1);
        end
        apply_table();
        drain();
        stall_mode = 1'b0;
        finish_test("random retire stalls", e0);

        e0 = errors;
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            rf_raddr <= 5'(r);
            @(negedge clk);
            if (r == 0 && rf_rdata !== 32'h0) begin
                $display("CHECK FAILED at %0t: r0 reads %h", $time, rf_rdata);
                errors++;
            end else if (r != 0 && written[r] && rf_rdata !== rf_model[r]) begin
                $display("CHECK FAILED at %0t: r%0d reads %h, expected %h",
                         $time, r, rf_rdata, rf_model[r]);
                errors++;
            end
        end
        finish_test("register file readback", e0);

        e0 = errors;
        add_row(3'd0, 3'd0, 32'h0000_0042, 32'h0, 32'h0, 32'h0, 1'b1, 5'd2, 1'b0, 1'b0, 1'b1);
        @(posedge clk);
        drive_row(table_q[0]);
        @(posedge clk);
        if (!in_ready) begin
            $display("CHECK FAILED at %0t: in_ready low on an empty pipe", $time);
            errors++;
        end
        record_accept(table_q[0]);
        in_valid <= 1'b0;
        table_q.delete();
        n = 1;
        forever begin
            @(negedge clk);
            if (retire_valid) break;
            @(posedge clk);
            n++;
            if (n > 20) abort_run("timeout waiting for retire_valid");
        end
        if (n != 3) begin
            $display("CHECK FAILED at %0t: retire after %0d edges, expected 3", $time, n);
            errors++;
        end
        drain();
        finish_test("single instruction latency", e0);

        $display("tests %0d, failed tests %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+.
pipe_pkg.sv
stage_if.sv
ex_issue.sv
mem_stage.sv
wb_stage.sv
mem_wb_top.sv
mem_wb_properties.sv
tb_mem_wb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module tb_mem_wb -o tb_mem_wb \
    > build.log 2>&1 &&
./obj_dir/tb_mem_wb > sim.log 2>&1 ||
{ echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -qx "All checks passed" sim.log && echo "PASS" ||
{ echo "FAIL, see sim.log"; exit 1; }
